// ==== bench/tb_udp_checksum_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_udp_checksum_gen;

    import udp_proto_pkg::*;
    import udp_stream_pkg::*;

    typedef logic [7:0] byte_q_t [$];

    localparam int CLK_PERIOD  = 4;
    localparam int NUM_FRAMES  = 81;
    localparam int MAX_BEATS   = 8;
    localparam int FRAME_SLACK = 64;
    localparam int WATCHDOG_NS = (NUM_FRAMES * (MAX_BEATS + FRAME_SLACK) + 100) * CLK_PERIOD;

    logic       clk = 1'b0;
    logic       rst;
    logic       s_hdr_valid;
    logic       s_hdr_ready;
    ip_addr_t   s_src_ip;
    ip_addr_t   s_dst_ip;
    port_t      s_src_port;
    port_t      s_dst_port;
    logic       s_payload_valid;
    logic       s_payload_ready;
    data_t      s_payload_data;
    keep_t      s_payload_keep;
    logic       s_payload_last;
    logic       m_hdr_valid;
    logic       m_hdr_ready = 1'b1;
    ip_addr_t   m_src_ip;
    ip_addr_t   m_dst_ip;
    port_t      m_src_port;
    port_t      m_dst_port;
    len16_t     m_udp_length;
    len16_t     m_udp_checksum;
    len16_t     m_ip_length;
    logic [7:0] m_ip_protocol;
    logic       m_payload_valid;
    logic       m_payload_ready = 1'b1;
    data_t      m_payload_data;
    keep_t      m_payload_keep;
    logic       m_payload_last;
    logic       busy;

    logic        stall_en = 1'b0;
    logic        track_busy = 1'b0;
    logic        busy_seen;
    logic        hdr_full_seen = 1'b0;
    int unsigned hdr_hold = 0;
    int unsigned pay_hold = 0;
    int          total_errors;

    // small FIFOs so back-pressure fills them quickly
    udp_checksum_gen #(
        .PAYLOAD_FIFO_DEPTH (32),
        .HEADER_FIFO_DEPTH  (4)
    ) dut (.*);

    udp_scoreboard sb (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // long low periods on the header side fill the header FIFO
    always @(posedge clk) begin
        if (!stall_en) begin
            m_hdr_ready     <= 1'b1;
            m_payload_ready <= 1'b1;
            hdr_hold        <= 0;
            pay_hold        <= 0;
        end else begin
            if (hdr_hold == 0) begin
                m_hdr_ready <= !m_hdr_ready;
                hdr_hold    <= m_hdr_ready ? $urandom_range(100, 8) : $urandom_range(12, 1);
            end else begin
                hdr_hold <= hdr_hold - 1;
            end
            if (pay_hold == 0) begin
                m_payload_ready <= !m_payload_ready;
                pay_hold        <= $urandom_range(8, 1);
            end else begin
                pay_hold <= pay_hold - 1;
            end
        end
    end

    always @(negedge clk) begin
        busy_seen     <= track_busy && (busy_seen || busy);
        hdr_full_seen <= hdr_full_seen || (stall_en && dut.hdr_fifo_full);
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

    // one's-complement sum over pseudo header, udp header and padded payload
    function automatic logic [15:0] ref_checksum(input udp_hdr_t h, input byte_q_t payload);
        logic [31:0] sum;
        logic [15:0] word;
        sum = 32'(h.src_ip[31:16]) + 32'(h.src_ip[15:0]) + 32'(h.dst_ip[31:16]) +
              32'(h.dst_ip[15:0]);
        sum += 32'd17 + 32'(h.udp_length) * 2 + 32'(h.src_port) + 32'(h.dst_port);
        for (int i = 0; i < payload.size(); i += 2) begin
            word[15:8] = payload[i];
            word[7:0]  = (i + 1 < payload.size()) ? payload[i + 1] : 8'h00;
            sum += 32'(word);
        end
        while (sum[31:16] != 0) begin
            sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        end
        return ~sum[15:0];
    endfunction

    task automatic send_frame(input udp_hdr_t h, input byte_q_t payload);
        beat_t b;
        int    nbeats;
        nbeats = (payload.size() + DATA_BYTES - 1) / DATA_BYTES;
        s_hdr_valid <= 1'b1;
        s_src_ip    <= h.src_ip;
        s_dst_ip    <= h.dst_ip;
        s_src_port  <= h.src_port;
        s_dst_port  <= h.dst_port;
        do @(negedge clk); while (!s_hdr_ready);
        @(posedge clk);
        s_hdr_valid <= 1'b0;
        for (int i = 0; i < nbeats; i++) begin
            b = '0;
            for (int k = 0; k < DATA_BYTES; k++) begin
                if (i * DATA_BYTES + k < payload.size()) begin
                    b.data[k*8 +: 8] = payload[i * DATA_BYTES + k];
                    b.keep[k]        = 1'b1;
                end
            end
            b.last = (i == nbeats - 1);
            sb.add_beat(b);
            s_payload_valid <= 1'b1;
            s_payload_data  <= b.data;
            s_payload_keep  <= b.keep;
            s_payload_last  <= b.last;
            do @(negedge clk); while (!s_payload_ready);
            @(posedge clk);
        end
        s_payload_valid <= 1'b0;
    endtask

    task automatic run_frame(input int len);
        udp_hdr_t h;
        byte_q_t  payload;
        h.src_ip   = $urandom;
        h.dst_ip   = $urandom;
        h.src_port = 16'($urandom);
        h.dst_port = 16'($urandom);
        for (int i = 0; i < len; i++) begin
            payload.push_back(8'($urandom));
        end
        h.udp_length   = 16'(len) + UDP_HDR_BYTES;
        h.udp_checksum = ref_checksum(h, payload);
        sb.add_header(h);
        send_frame(h, payload);
    endtask

    task automatic drain_outputs();
        do @(posedge clk); while (sb.outstanding() != 0);
    endtask

    initial begin
        void'($urandom(50));
        rst             = 1'b1;
        s_hdr_valid     = 1'b0;
        s_src_ip        = '0;
        s_dst_ip        = '0;
        s_src_port      = '0;
        s_dst_port      = '0;
        s_payload_valid = 1'b0;
        s_payload_data  = '0;
        s_payload_keep  = '0;
        s_payload_last  = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        sb.expect_level("m_hdr_valid after reset", m_hdr_valid, 1'b0);
        sb.expect_level("m_payload_valid after reset", m_payload_valid, 1'b0);
        sb.expect_level("busy after reset", busy, 1'b0);
        sb.expect_level("s_hdr_ready after reset", s_hdr_ready, 1'b0);
        sb.expect_level("s_payload_ready after reset", s_payload_ready, 1'b0);
        @(posedge clk);
        sb.end_test("reset_state");

        track_busy = 1'b1;
        run_frame(16);
        drain_outputs();
        @(negedge clk);
        sb.expect_level("busy during frame", busy_seen, 1'b1);
        sb.expect_level("busy after frame", busy, 1'b0);
        track_busy = 1'b0;
        @(posedge clk);
        sb.end_test("single_frame");

        repeat (30) begin
            run_frame(int'($urandom_range(64, 1)));
            drain_outputs();
        end
        sb.end_test("random_lengths");

        // next header follows the last beat with no gap
        repeat (20) run_frame(int'($urandom_range(64, 1)));
        drain_outputs();
        sb.end_test("back_to_back");

        stall_en <= 1'b1;
        repeat (30) run_frame(int'($urandom_range(64, 1)));
        drain_outputs();
        stall_en <= 1'b0;
        sb.expect_level("header FIFO full during stalls", hdr_full_seen, 1'b1);
        sb.end_test("backpressure");

        total_errors = sb.error_total + dut.csum_checks.assert_failures;
        $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 sb.test_total, sb.failed_total, sb.check_total, sb.error_total,
                 dut.csum_checks.assert_failures);
        if (total_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/udp_checksum_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module udp_checksum_checker (
    input wire                        clk,
    input wire                        rst,
    input wire                        m_hdr_valid,
    input wire                        m_hdr_ready,
    input wire udp_proto_pkg::len16_t m_udp_length,
    input wire udp_proto_pkg::len16_t m_udp_checksum,
    input wire udp_proto_pkg::len16_t m_ip_length,
    input wire                        m_payload_valid,
    input wire                        m_payload_ready,
    input wire udp_stream_pkg::data_t m_payload_data
);

    int assert_failures = 0;

    // a stalled header stays on the outputs until taken
    hdr_held: assert property (@(posedge clk) disable iff (rst)
        m_hdr_valid && !m_hdr_ready |=> m_hdr_valid && $stable(m_udp_checksum)
            && $stable(m_udp_length))
        else begin
            $error("header valid or fields changed before ready");
            assert_failures++;
        end

    payload_held: assert property (@(posedge clk) disable iff (rst)
        m_payload_valid && !m_payload_ready |=> m_payload_valid && $stable(m_payload_data))
        else begin
            $error("payload valid or data changed before ready");
            assert_failures++;
        end

    // second reset cycle onward, pointers are settled
    quiet_in_reset: assert property (@(posedge clk)
        rst && $past(rst) |-> !m_hdr_valid && !m_payload_valid)
        else begin
            $error("output valid raised during reset");
            assert_failures++;
        end

    ip_len_rule: assert property (@(posedge clk) disable iff (rst)
        m_hdr_valid |-> m_ip_length == m_udp_length + 16'd20)
        else begin
            $error("ip length is not udp length plus 20");
            assert_failures++;
        end

endmodule

bind udp_checksum_gen udp_checksum_checker csum_checks (.*);

`default_nettype wire

// ==== bench/udp_scoreboard.sv ====
`timescale 1ns/100ps
`default_nettype none

module udp_scoreboard (
    input wire                          clk,
    input wire                          rst,
    input wire                          m_hdr_valid,
    input wire                          m_hdr_ready,
    input wire udp_proto_pkg::ip_addr_t m_src_ip,
    input wire udp_proto_pkg::ip_addr_t m_dst_ip,
    input wire udp_proto_pkg::port_t    m_src_port,
    input wire udp_proto_pkg::port_t    m_dst_port,
    input wire udp_proto_pkg::len16_t   m_udp_length,
    input wire udp_proto_pkg::len16_t   m_udp_checksum,
    input wire udp_proto_pkg::len16_t   m_ip_length,
    input wire [7:0]                    m_ip_protocol,
    input wire                          m_payload_valid,
    input wire                          m_payload_ready,
    input wire udp_stream_pkg::data_t   m_payload_data,
    input wire udp_stream_pkg::keep_t   m_payload_keep,
    input wire                          m_payload_last
);

    import udp_proto_pkg::*;
    import udp_stream_pkg::*;

    udp_hdr_t exp_hdr_q [$];
    beat_t    exp_beat_q [$];
    udp_hdr_t exp_hdr;
    beat_t    exp_beat;

    int test_errors  = 0;
    int test_frames  = 0;
    int error_total  = 0;
    int check_total  = 0;
    int test_total   = 0;
    int failed_total = 0;

    task automatic add_header(input udp_hdr_t h);
        exp_hdr_q.push_back(h);
    endtask

    task automatic add_beat(input beat_t b);
        exp_beat_q.push_back(b);
    endtask

    function automatic int outstanding();
        return exp_hdr_q.size() + exp_beat_q.size();
    endfunction

    task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
        check_total++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic expect_level(input string what, input logic got, input logic exp);
        compare(what, 64'(got), 64'(exp));
    endtask

    task automatic end_test(input string name);
        test_total++;
        if (test_errors == 0) begin
            $display("test %s passed, %0d frames", name, test_frames);
        end else begin
            $display("test %s failed, %0d errors", name, test_errors);
            failed_total++;
        end
        error_total += test_errors;
        test_errors = 0;
        test_frames = 0;
    endtask

    // transfers seen at the falling edge complete on the next rising edge
    always @(negedge clk) begin
        if (!rst && m_hdr_valid && m_hdr_ready) begin
            if (exp_hdr_q.size() == 0) begin
                $display("ERROR at %0t: a header came out with no frame expected", $time);
                test_errors++;
            end else begin
                exp_hdr = exp_hdr_q.pop_front();
                test_frames++;
                compare("src_ip", 64'(m_src_ip), 64'(exp_hdr.src_ip));
                compare("dst_ip", 64'(m_dst_ip), 64'(exp_hdr.dst_ip));
                compare("src_port", 64'(m_src_port), 64'(exp_hdr.src_port));
                compare("dst_port", 64'(m_dst_port), 64'(exp_hdr.dst_port));
                compare("udp_length", 64'(m_udp_length), 64'(exp_hdr.udp_length));
                compare("udp_checksum", 64'(m_udp_checksum), 64'(exp_hdr.udp_checksum));
                compare("ip_length", 64'(m_ip_length), 64'(exp_hdr.udp_length + 16'd20));
                compare("ip_protocol", 64'(m_ip_protocol), 64'd17);
            end
        end
        if (!rst && m_payload_valid && m_payload_ready) begin
            if (exp_beat_q.size() == 0) begin
                $display("ERROR at %0t: a payload beat came out with none expected", $time);
                test_errors++;
            end else begin
                exp_beat = exp_beat_q.pop_front();
                compare("payload_data", m_payload_data, exp_beat.data);
                compare("payload_keep", 64'(m_payload_keep), 64'(exp_beat.keep));
                compare("payload_last", 64'(m_payload_last), 64'(exp_beat.last));
            end
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
hw/udp_proto_pkg.sv
hw/udp_stream_pkg.sv
hw/sync_fifo.sv
hw/udp_csum_accum.sv
hw/udp_checksum_gen.sv
bench/udp_checksum_checker.sv
bench/udp_scoreboard.sv
bench/tb_udp_checksum_gen.sv

// ==== hw/sync_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 16
) (
    input  wire   clk,
    input  wire   rst,

    input  wire   wr_en,
    input  wire T wr_data,
    output logic  full,

    input  wire   rd_ready,
    output logic  rd_valid,
    output T      rd_data
);

    localparam int AW = $clog2(DEPTH);

    T mem [DEPTH];

    // extra msb tells a full FIFO from an empty one
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        rd_en;

    // full when the wrap bits differ and the rest match
    assign full = (wr_ptr[AW] != rd_ptr[AW]) &&
                  (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign rd_valid = (wr_ptr != rd_ptr);
    assign rd_en    = rd_valid && rd_ready;

    // head item always on the output
    assign rd_data = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/udp_checksum_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module udp_checksum_gen #(
    parameter int PAYLOAD_FIFO_DEPTH = 256,
    parameter int HEADER_FIFO_DEPTH  = 8
) (
    input  wire                          clk,
    input  wire                          rst,

    input  wire                          s_hdr_valid,
    output logic                         s_hdr_ready,
    input  wire udp_proto_pkg::ip_addr_t s_src_ip,
    input  wire udp_proto_pkg::ip_addr_t s_dst_ip,
    input  wire udp_proto_pkg::port_t    s_src_port,
    input  wire udp_proto_pkg::port_t    s_dst_port,

    input  wire                          s_payload_valid,
    output logic                         s_payload_ready,
    input  wire udp_stream_pkg::data_t   s_payload_data,
    input  wire udp_stream_pkg::keep_t   s_payload_keep,
    input  wire                          s_payload_last,

    output logic                         m_hdr_valid,
    input  wire                          m_hdr_ready,
    output udp_proto_pkg::ip_addr_t      m_src_ip,
    output udp_proto_pkg::ip_addr_t      m_dst_ip,
    output udp_proto_pkg::port_t         m_src_port,
    output udp_proto_pkg::port_t         m_dst_port,
    output udp_proto_pkg::len16_t        m_udp_length,
    output udp_proto_pkg::len16_t        m_udp_checksum,
    output udp_proto_pkg::len16_t        m_ip_length,
    output logic [7:0]                   m_ip_protocol,

    output logic                         m_payload_valid,
    input  wire                          m_payload_ready,
    output udp_stream_pkg::data_t        m_payload_data,
    output udp_stream_pkg::keep_t        m_payload_keep,
    output logic                         m_payload_last,

    output logic                         busy
);

    import udp_proto_pkg::*;
    import udp_stream_pkg::*;

    logic     beat_fifo_full;
    logic     beat_wr;
    beat_t    beat_in;
    beat_t    beat_out;
    logic     hdr_fifo_full;
    logic     res_valid;
    udp_hdr_t res;
    udp_hdr_t hdr_out;

    udp_csum_accum accum (
        .clk             (clk),
        .rst             (rst),
        .s_hdr_valid     (s_hdr_valid),
        .s_hdr_ready     (s_hdr_ready),
        .s_src_ip        (s_src_ip),
        .s_dst_ip        (s_dst_ip),
        .s_src_port      (s_src_port),
        .s_dst_port      (s_dst_port),
        .s_payload_valid (s_payload_valid),
        .s_payload_ready (s_payload_ready),
        .s_payload_data  (s_payload_data),
        .s_payload_keep  (s_payload_keep),
        .s_payload_last  (s_payload_last),
        .beat_fifo_full  (beat_fifo_full),
        .beat_wr         (beat_wr),
        .beat            (beat_in),
        .hdr_fifo_full   (hdr_fifo_full),
        .res_valid       (res_valid),
        .res             (res),
        .busy            (busy)
    );

    // one entry per finished frame
    sync_fifo #(
        .T     (udp_hdr_t),
        .DEPTH (HEADER_FIFO_DEPTH)
    ) hdr_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (res_valid),
        .wr_data  (res),
        .full     (hdr_fifo_full),
        .rd_ready (m_hdr_ready),
        .rd_valid (m_hdr_valid),
        .rd_data  (hdr_out)
    );

    // payload waits here until its header is complete
    sync_fifo #(
        .T     (beat_t),
        .DEPTH (PAYLOAD_FIFO_DEPTH)
    ) payload_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (beat_wr),
        .wr_data  (beat_in),
        .full     (beat_fifo_full),
        .rd_ready (m_payload_ready),
        .rd_valid (m_payload_valid),
        .rd_data  (beat_out)
    );

    assign m_src_ip       = hdr_out.src_ip;
    assign m_dst_ip       = hdr_out.dst_ip;
    assign m_src_port     = hdr_out.src_port;
    assign m_dst_port     = hdr_out.dst_port;
    assign m_udp_length   = hdr_out.udp_length;
    assign m_udp_checksum = hdr_out.udp_checksum;

    // ip total length covers the 20 byte ipv4 header
    assign m_ip_length   = hdr_out.udp_length + IP_HDR_BYTES;
    assign m_ip_protocol = UDP_PROTOCOL;

    assign m_payload_data = beat_out.data;
    assign m_payload_keep = beat_out.keep;
    assign m_payload_last = beat_out.last;

endmodule

`default_nettype wire

// ==== hw/udp_csum_accum.sv ====
`timescale 1ns/100ps
`default_nettype none

module udp_csum_accum (
    input  wire                          clk,
    input  wire                          rst,

    input  wire                          s_hdr_valid,
    output logic                         s_hdr_ready,
    input  wire udp_proto_pkg::ip_addr_t s_src_ip,
    input  wire udp_proto_pkg::ip_addr_t s_dst_ip,
    input  wire udp_proto_pkg::port_t    s_src_port,
    input  wire udp_proto_pkg::port_t    s_dst_port,

    input  wire                          s_payload_valid,
    output logic                         s_payload_ready,
    input  wire udp_stream_pkg::data_t   s_payload_data,
    input  wire udp_stream_pkg::keep_t   s_payload_keep,
    input  wire                          s_payload_last,

    input  wire                          beat_fifo_full,
    output logic                         beat_wr,
    output udp_stream_pkg::beat_t        beat,

    input  wire                          hdr_fifo_full,
    output logic                         res_valid,
    output udp_proto_pkg::udp_hdr_t      res,

    output logic                         busy
);

    import udp_proto_pkg::*;
    import udp_stream_pkg::*;

    localparam int CNT_W = $clog2(DATA_BYTES) + 1;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SUM_HDR,
        ST_SUM_PAYLOAD,
        ST_FINISH_1,
        ST_FINISH_2
    } state_t;

    state_t state;
    state_t state_next;

    logic        hdr_xfer;
    logic        hdr_ready_next;
    logic        res_valid_next;

    logic [31:0] csum_reg;
    logic [31:0] csum_next;
    logic [16:0] sum_t1;
    logic [16:0] sum_t1_next;
    logic [16:0] sum_t2;
    logic [16:0] sum_t2_next;
    len16_t      len_reg;
    len16_t      len_next;

    ip_addr_t    src_ip_reg;
    ip_addr_t    dst_ip_reg;
    port_t       src_port_reg;
    port_t       dst_port_reg;

    logic [16:0] lane_part;
    logic [16:0] lane_sum_lo;
    logic [16:0] lane_sum_hi;
    logic [CNT_W-1:0] byte_cnt;
    logic [16:0] fold;
    logic [15:0] folded;

    assign hdr_xfer        = s_hdr_valid && s_hdr_ready;
    assign s_payload_ready = (state == ST_SUM_PAYLOAD) && !beat_fifo_full;
    assign beat_wr         = s_payload_valid && s_payload_ready;

    assign beat.data = s_payload_data;
    assign beat.keep = s_payload_keep;
    assign beat.last = s_payload_last;

    // even lanes take the high byte of a 16-bit word, odd lanes the low byte
    always_comb begin
        lane_part   = '0;
        lane_sum_lo = '0;
        lane_sum_hi = '0;
        byte_cnt    = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (s_payload_keep[i]) begin
                byte_cnt = CNT_W'(i + 1);
                if (i % 2 == 1) begin
                    lane_part = {9'd0, s_payload_data[i*8 +: 8]};
                end else begin
                    lane_part = {1'b0, s_payload_data[i*8 +: 8], 8'h00};
                end
                if (i < DATA_BYTES / 2) begin
                    lane_sum_lo = lane_sum_lo + lane_part;
                end else begin
                    lane_sum_hi = lane_sum_hi + lane_part;
                end
            end
        end
    end

    // end-around carry folded back in two steps
    assign fold   = {1'b0, csum_reg[15:0]} + {1'b0, csum_reg[31:16]};
    assign folded = fold[15:0] + {15'd0, fold[16]};

    always_comb begin
        state_next     = state;
        hdr_ready_next = 1'b0;
        res_valid_next = 1'b0;
        csum_next      = csum_reg;
        sum_t1_next    = sum_t1;
        sum_t2_next    = sum_t2;
        len_next       = len_reg;

        case (state)
            ST_IDLE: begin
                // hold off while a result is still landing in the header FIFO
                hdr_ready_next = !hdr_fifo_full && !res_valid && !hdr_xfer;
                if (hdr_xfer) begin
                    // protocol plus udp header length counted twice
                    csum_next   = {24'd0, UDP_PROTOCOL} + {15'd0, UDP_HDR_BYTES, 1'b0};
                    sum_t1_next = {1'b0, s_src_ip[31:16]};
                    sum_t2_next = {1'b0, s_src_ip[15:0]};
                    len_next    = UDP_HDR_BYTES;
                    state_next  = ST_SUM_HDR;
                end
            end
            ST_SUM_HDR: begin
                csum_next   = csum_reg + {15'd0, sum_t1} + {15'd0, sum_t2};
                sum_t1_next = {1'b0, dst_ip_reg[31:16]} + {1'b0, dst_ip_reg[15:0]};
                sum_t2_next = {1'b0, src_port_reg} + {1'b0, dst_port_reg};
                state_next  = ST_SUM_PAYLOAD;
            end
            ST_SUM_PAYLOAD: begin
                if (beat_wr) begin
                    // byte count twice for the two length fields in the sum
                    csum_next   = csum_reg + {15'd0, sum_t1} + {15'd0, sum_t2} +
                                  32'({byte_cnt, 1'b0});
                    sum_t1_next = lane_sum_lo;
                    sum_t2_next = lane_sum_hi;
                    len_next    = len_reg + 16'(byte_cnt);
                    if (s_payload_last) begin
                        state_next = ST_FINISH_1;
                    end
                end
            end
            ST_FINISH_1: begin
                // drain the last staged partial sums
                csum_next  = csum_reg + {15'd0, sum_t1} + {15'd0, sum_t2};
                state_next = ST_FINISH_2;
            end
            ST_FINISH_2: begin
                csum_next      = {16'd0, ~folded};
                res_valid_next = 1'b1;
                state_next     = ST_IDLE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            s_hdr_ready <= 1'b0;
            res_valid   <= 1'b0;
            busy        <= 1'b0;
        end else begin
            state       <= state_next;
            s_hdr_ready <= hdr_ready_next;
            res_valid   <= res_valid_next;
            busy        <= (state_next != ST_IDLE);
        end

        csum_reg <= csum_next;
        sum_t1   <= sum_t1_next;
        sum_t2   <= sum_t2_next;
        len_reg  <= len_next;

        if (hdr_xfer) begin
            src_ip_reg   <= s_src_ip;
            dst_ip_reg   <= s_dst_ip;
            src_port_reg <= s_src_port;
            dst_port_reg <= s_dst_port;
        end
    end

    assign res.src_ip       = src_ip_reg;
    assign res.dst_ip       = dst_ip_reg;
    assign res.src_port     = src_port_reg;
    assign res.dst_port     = dst_port_reg;
    assign res.udp_length   = len_reg;
    assign res.udp_checksum = csum_reg[15:0];

endmodule

`default_nettype wire

// ==== hw/udp_proto_pkg.sv ====
`default_nettype none

package udp_proto_pkg;

    // ipv4 and udp header field types
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] port_t;
    typedef logic [15:0] len16_t;

    // ip protocol number of udp
    localparam logic [7:0] UDP_PROTOCOL = 8'd17;
    localparam len16_t IP_HDR_BYTES = 16'd20;
    localparam len16_t UDP_HDR_BYTES = 16'd8;

    // completed header, one entry of the header FIFO
    typedef struct packed {
        ip_addr_t src_ip;
        ip_addr_t dst_ip;
        port_t    src_port;
        port_t    dst_port;
        len16_t   udp_length;
        len16_t   udp_checksum;
    } udp_hdr_t;

endpackage

`default_nettype wire

// ==== hw/udp_stream_pkg.sv ====
`default_nettype none

package udp_stream_pkg;

    // bytes per payload word
    localparam int DATA_BYTES = 8;

    typedef logic [DATA_BYTES*8-1:0] data_t;
    typedef logic [DATA_BYTES-1:0]   keep_t;

    // one payload beat as held in the payload FIFO
    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
    } beat_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the udp checksum testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_udp_checksum_gen -f files.f \
    && { ./obj_dir/Vtb_udp_checksum_gen +verilator+error+limit+1000 > sim.log 2>&1 || true; } \
    && cat sim.log \
    && grep -qx "=== PASS ===" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
